/* rv_isa_pkg.sv */
package rv_isa_pkg;

    // base integer width and register index width of RV32I
    localparam int XLEN = 32;
    localparam int REG_ADDR_W = 5;

    // major opcodes in bits 6:0 of the instruction word, only the ones this hart executes
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_BRANCH = 7'b1100011,
        OPC_SYSTEM = 7'b1110011
    } opcode_e;

    // funct3 of register and immediate ALU ops
    // shifts right share one code and are split by funct7 bit 5
    typedef enum logic [2:0] {
        F3_ADD  = 3'b000,
        F3_SLL  = 3'b001,
        F3_SLT  = 3'b010,
        F3_SLTU = 3'b011,
        F3_XOR  = 3'b100,
        F3_SR   = 3'b101,
        F3_OR   = 3'b110,
        F3_AND  = 3'b111
    } alu_funct3_e;

    // funct3 of the conditional branches, codes 010 and 011 are reserved
    typedef enum logic [2:0] {
        F3_BEQ  = 3'b000,
        F3_BNE  = 3'b001,
        F3_BLT  = 3'b100,
        F3_BGE  = 3'b101,
        F3_BLTU = 3'b110,
        F3_BGEU = 3'b111
    } branch_funct3_e;

    // ebreak is the only system word accepted
    localparam logic [31:0] EBREAK_WORD = 32'h0010_0073;
    // addi x0, x0, 0
    localparam logic [31:0] NOP_WORD = 32'h0000_0013;

endpackage

/* hart_pkg.sv */
package hart_pkg;

    // first fetch address after reset
    localparam logic [rv_isa_pkg::XLEN-1:0] RESET_ADDR = 32'h0000_0000;
    // architectural register count, x0 included
    localparam int NUM_REGS = 32;

    typedef enum logic [1:0] {
        FETCH_IDLE,
        FETCH_REQUEST,
        FETCH_WAIT_RSP,
        FETCH_STOPPED
    } fetch_state_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B
    } alu_op_e;

    // instruction word as returned by imem, with the address it came from
    typedef struct packed {
        logic [31:0] inst;
        logic [31:0] pc;
    } fetch_pkt_t;

    typedef struct packed {
        alu_op_e                    alu_op;
        logic                       a_is_pc;
        logic                       b_is_imm;
        logic                       is_branch;
        rv_isa_pkg::branch_funct3_e branch_f3;
        logic                       is_jal;
        logic [4:0]                 rs1_addr;
        logic                       rs1_used;
        logic [4:0]                 rs2_addr;
        logic                       rs2_used;
        logic [4:0]                 rd_addr;
        logic                       rd_wen;
        logic [31:0]                imm;
        logic                       illegal;
        logic                       halt;
    } decoded_t;

    typedef struct packed {
        logic [31:0] result;
        logic [31:0] next_pc;
        logic        taken;
        logic        misaligned;
    } exec_result_t;

    // one retired instruction as seen on the retire port
    typedef struct packed {
        logic [31:0] inst;
        logic        trap;
        logic        halt;
        logic [4:0]  rs1_raddr;
        logic [4:0]  rs2_raddr;
        logic [31:0] rs1_rdata;
        logic [31:0] rs2_rdata;
        logic [4:0]  rd_waddr;
        logic [31:0] rd_wdata;
        logic [31:0] pc;
        logic [31:0] next_pc;
    } retire_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] next_pc;
        logic        stop;
    } redirect_t;

endpackage

/* fetch_unit.sv */
`timescale 1ns/100ps

module fetch_unit (
    input  logic                 i_clk,
    input  logic                 i_rst,
    input  logic                 i_imem_ready,
    input  logic                 i_imem_valid,
    input  logic [31:0]          i_imem_rdata,
    input  hart_pkg::redirect_t  i_redirect,
    output logic                 o_imem_ren,
    output logic [31:0]          o_imem_raddr,
    output logic                 o_fetch_valid,
    output hart_pkg::fetch_pkt_t o_fetch
);
    import hart_pkg::*;

    fetch_state_e state_q;
    fetch_state_e state_d;
    logic [31:0]  pc_q;
    logic [31:0]  req_addr;
    logic         go_next;
    logic         accept;

    // a redirect only ever shows up in idle, the cycle after a response
    // without one, idle is the state left by reset and starts at pc_q
    assign go_next = (state_q == FETCH_IDLE) && i_redirect.valid && !i_redirect.stop;
    assign req_addr = i_redirect.valid ? i_redirect.next_pc : pc_q;

    // the request following a retire goes out in the retire cycle itself
    assign o_imem_ren = (state_q == FETCH_REQUEST) || go_next;
    assign o_imem_raddr = req_addr;
    assign accept = o_imem_ren && i_imem_ready;

    // the response may land in the accept cycle or any cycle after it
    assign o_fetch_valid = i_imem_valid && (accept || state_q == FETCH_WAIT_RSP);
    assign o_fetch.inst = i_imem_rdata;
    assign o_fetch.pc = req_addr;

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            FETCH_IDLE: begin
                if (!i_redirect.valid) begin
                    state_d = FETCH_REQUEST;
                end else if (i_redirect.stop) begin
                    state_d = FETCH_STOPPED;
                end else begin
                    state_d = o_fetch_valid ? FETCH_IDLE
                            : accept ? FETCH_WAIT_RSP : FETCH_REQUEST;
                end
            end
            FETCH_REQUEST: begin
                state_d = o_fetch_valid ? FETCH_IDLE
                        : accept ? FETCH_WAIT_RSP : FETCH_REQUEST;
            end
            FETCH_WAIT_RSP: begin
                if (i_imem_valid) begin
                    state_d = FETCH_IDLE;
                end
            end
            // only reset leaves this state
            FETCH_STOPPED: state_d = FETCH_STOPPED;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state_q <= FETCH_IDLE;
            pc_q <= RESET_ADDR;
        end else begin
            state_q <= state_d;
            // pc_q keeps the address of the request in flight
            pc_q <= req_addr;
        end
    end

endmodule

/* decoder.sv */
`timescale 1ns/100ps

module decoder (
    input  hart_pkg::fetch_pkt_t i_fetch,
    output hart_pkg::decoded_t   o_dec
);
    import rv_isa_pkg::*;
    import hart_pkg::*;

    opcode_e                opcode;
    logic [2:0]             funct3;
    logic [6:0]             funct7;
    logic [XLEN-1:0]        imm_i;
    logic [XLEN-1:0]        imm_u;
    logic [XLEN-1:0]        imm_b;
    logic [XLEN-1:0]        imm_j;
    alu_op_e                f3_op;
    logic                   op_f7_ok;
    logic                   imm_f7_ok;

    assign opcode = opcode_e'(i_fetch.inst[6:0]);
    assign funct3 = i_fetch.inst[14:12];
    assign funct7 = i_fetch.inst[31:25];

    // immediates are always sign extended from bit 31
    assign imm_i = {{20{i_fetch.inst[31]}}, i_fetch.inst[31:20]};
    assign imm_u = {i_fetch.inst[31:12], 12'b0};
    assign imm_b = {{20{i_fetch.inst[31]}}, i_fetch.inst[7], i_fetch.inst[30:25],
                    i_fetch.inst[11:8], 1'b0};
    assign imm_j = {{12{i_fetch.inst[31]}}, i_fetch.inst[19:12], i_fetch.inst[20],
                    i_fetch.inst[30:21], 1'b0};

    // register ops only accept funct7 of zero, or 0x20 for sub and sra
    assign op_f7_ok = (funct7 == 7'h00) ||
                      (funct7 == 7'h20 && (funct3 == F3_ADD || funct3 == F3_SR));
    // on immediates funct7 only exists for the shifts, the rest is immediate
    assign imm_f7_ok = (funct3 == F3_SLL) ? (funct7 == 7'h00)
                     : (funct3 == F3_SR) ? (funct7 == 7'h00 || funct7 == 7'h20)
                     : 1'b1;

    always_comb begin
        unique case (alu_funct3_e'(funct3))
            F3_ADD:  f3_op = ALU_ADD;
            F3_SLL:  f3_op = ALU_SLL;
            F3_SLT:  f3_op = ALU_SLT;
            F3_SLTU: f3_op = ALU_SLTU;
            F3_XOR:  f3_op = ALU_XOR;
            F3_SR:   f3_op = funct7[5] ? ALU_SRA : ALU_SRL;
            F3_OR:   f3_op = ALU_OR;
            F3_AND:  f3_op = ALU_AND;
        endcase
    end

    always_comb begin
        o_dec = '0;
        o_dec.alu_op = f3_op;
        o_dec.branch_f3 = branch_funct3_e'(funct3);
        o_dec.rs1_addr = i_fetch.inst[19:15];
        o_dec.rs2_addr = i_fetch.inst[24:20];
        o_dec.rd_addr = i_fetch.inst[11:7];
        unique case (opcode)
            OPC_OP: begin
                o_dec.rs1_used = 1'b1;
                o_dec.rs2_used = 1'b1;
                o_dec.rd_wen = 1'b1;
                if (funct3 == F3_ADD && funct7[5]) begin
                    o_dec.alu_op = ALU_SUB;
                end
                o_dec.illegal = !op_f7_ok;
            end
            OPC_OP_IMM: begin
                // addi has no subtract form, so bit 30 is only immediate here
                o_dec.rs1_used = 1'b1;
                o_dec.rd_wen = 1'b1;
                o_dec.b_is_imm = 1'b1;
                o_dec.imm = imm_i;
                o_dec.illegal = !imm_f7_ok;
            end
            OPC_LUI: begin
                o_dec.alu_op = ALU_PASS_B;
                o_dec.b_is_imm = 1'b1;
                o_dec.rd_wen = 1'b1;
                o_dec.imm = imm_u;
            end
            OPC_AUIPC: begin
                o_dec.alu_op = ALU_ADD;
                o_dec.a_is_pc = 1'b1;
                o_dec.b_is_imm = 1'b1;
                o_dec.rd_wen = 1'b1;
                o_dec.imm = imm_u;
            end
            OPC_JAL: begin
                o_dec.is_jal = 1'b1;
                o_dec.rd_wen = 1'b1;
                o_dec.imm = imm_j;
            end
            OPC_BRANCH: begin
                o_dec.is_branch = 1'b1;
                o_dec.rs1_used = 1'b1;
                o_dec.rs2_used = 1'b1;
                o_dec.imm = imm_b;
                o_dec.illegal = (funct3[2:1] == 2'b01);
            end
            OPC_SYSTEM: begin
                o_dec.halt = (i_fetch.inst == EBREAK_WORD);
                o_dec.illegal = (i_fetch.inst != EBREAK_WORD);
            end
            // loads, stores, jalr and fence all land here
            default: o_dec.illegal = 1'b1;
        endcase
    end

endmodule

/* reg_file.sv */
`timescale 1ns/100ps

module reg_file (
    input  logic        i_clk,
    input  logic        i_rst,
    input  logic [4:0]  i_rs1_addr,
    input  logic [4:0]  i_rs2_addr,
    output logic [31:0] o_rs1_data,
    output logic [31:0] o_rs2_data,
    input  logic        i_rd_wen,
    input  logic [4:0]  i_rd_addr,
    input  logic [31:0] i_rd_data
);
    import hart_pkg::*;

    logic [31:0] regs [NUM_REGS];

    // entry 0 is cleared by reset and never written after that
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_rd_wen && i_rd_addr != 5'd0) begin
            regs[i_rd_addr] <= i_rd_data;
        end
    end

    // reads are combinational, a write shows up after the edge
    assign o_rs1_data = (i_rs1_addr == 5'd0) ? 32'd0 : regs[i_rs1_addr];
    assign o_rs2_data = (i_rs2_addr == 5'd0) ? 32'd0 : regs[i_rs2_addr];

endmodule

/* execute_unit.sv */
`timescale 1ns/100ps

module execute_unit (
    input  hart_pkg::decoded_t           i_dec,
    input  logic [rv_isa_pkg::XLEN-1:0]  i_pc,
    input  logic [rv_isa_pkg::XLEN-1:0]  i_rs1_data,
    input  logic [rv_isa_pkg::XLEN-1:0]  i_rs2_data,
    output hart_pkg::exec_result_t       o_exec
);
    import rv_isa_pkg::*;
    import hart_pkg::*;

    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] alu;
    logic [XLEN-1:0] pc_plus4;
    logic [XLEN-1:0] target;
    logic [4:0]      shamt;
    logic            cond;
    logic            taken;

    assign op_a = i_dec.a_is_pc ? i_pc : i_rs1_data;
    assign op_b = i_dec.b_is_imm ? i_dec.imm : i_rs2_data;
    // shifts use only the low five bits, which also drops the srai marker bit
    assign shamt = op_b[4:0];

    always_comb begin
        unique case (i_dec.alu_op)
            ALU_ADD:    alu = op_a + op_b;
            ALU_SUB:    alu = op_a - op_b;
            ALU_SLL:    alu = op_a << shamt;
            ALU_SLT:    alu = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            ALU_SLTU:   alu = {{(XLEN-1){1'b0}}, op_a < op_b};
            ALU_XOR:    alu = op_a ^ op_b;
            ALU_SRL:    alu = op_a >> shamt;
            ALU_SRA:    alu = $signed(op_a) >>> shamt;
            ALU_OR:     alu = op_a | op_b;
            ALU_AND:    alu = op_a & op_b;
            ALU_PASS_B: alu = op_b;
            default:    alu = '0;
        endcase
    end

    // branches compare the register values, never the selected operands
    always_comb begin
        unique case (i_dec.branch_f3)
            F3_BEQ:  cond = (i_rs1_data == i_rs2_data);
            F3_BNE:  cond = (i_rs1_data != i_rs2_data);
            F3_BLT:  cond = $signed(i_rs1_data) < $signed(i_rs2_data);
            F3_BGE:  cond = $signed(i_rs1_data) >= $signed(i_rs2_data);
            F3_BLTU: cond = i_rs1_data < i_rs2_data;
            F3_BGEU: cond = i_rs1_data >= i_rs2_data;
            default: cond = 1'b0;
        endcase
    end

    assign pc_plus4 = i_pc + 32'd4;
    // branch and jal targets are both pc relative
    assign target = i_pc + i_dec.imm;
    assign taken = i_dec.is_jal || (i_dec.is_branch && cond);

    assign o_exec.result = i_dec.is_jal ? pc_plus4 : alu;
    assign o_exec.next_pc = taken ? target : pc_plus4;
    assign o_exec.taken = taken;
    // a fall-through pc is always aligned, so only a taken target can trap
    assign o_exec.misaligned = taken && (target[1:0] != 2'b00);

endmodule

/* retire_stage.sv */
`timescale 1ns/100ps

module retire_stage (
    input  logic                   i_clk,
    input  logic                   i_rst,
    input  logic                   i_fetch_valid,
    input  hart_pkg::fetch_pkt_t   i_fetch,
    input  hart_pkg::decoded_t     i_dec,
    input  logic [31:0]            i_rs1_data,
    input  logic [31:0]            i_rs2_data,
    input  hart_pkg::exec_result_t i_exec,
    output logic                   o_rd_wen,
    output logic [4:0]             o_rd_addr,
    output logic [31:0]            o_rd_data,
    output hart_pkg::redirect_t    o_redirect,
    output hart_pkg::retire_t      o_retire,
    output logic                   o_retire_valid
);
    import hart_pkg::*;

    retire_t ret_d;
    retire_t ret_q;
    logic    valid_q;
    logic    trap;
    logic    rd_live;

    assign trap = i_dec.illegal || i_exec.misaligned;
    // a trapping instruction leaves the register file untouched
    assign rd_live = i_dec.rd_wen && !trap && (i_dec.rd_addr != 5'd0);

    always_comb begin
        ret_d.inst = i_fetch.inst;
        ret_d.trap = trap;
        ret_d.halt = i_dec.halt;
        // unused source fields read as zero on the retire port
        ret_d.rs1_raddr = i_dec.rs1_used ? i_dec.rs1_addr : 5'd0;
        ret_d.rs2_raddr = i_dec.rs2_used ? i_dec.rs2_addr : 5'd0;
        ret_d.rs1_rdata = i_dec.rs1_used ? i_rs1_data : 32'd0;
        ret_d.rs2_rdata = i_dec.rs2_used ? i_rs2_data : 32'd0;
        ret_d.rd_waddr = rd_live ? i_dec.rd_addr : 5'd0;
        ret_d.rd_wdata = rd_live ? i_exec.result : 32'd0;
        ret_d.pc = i_fetch.pc;
        ret_d.next_pc = i_exec.next_pc;
    end

    // writeback happens on the same edge that captures the record
    assign o_rd_wen = i_fetch_valid && rd_live;
    assign o_rd_addr = ret_d.rd_waddr;
    assign o_rd_data = ret_d.rd_wdata;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= i_fetch_valid;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_fetch_valid) begin
            ret_q <= ret_d;
        end
    end

    // fetch follows the registered copy, so it restarts in the retire cycle
    assign o_redirect.valid = valid_q;
    assign o_redirect.next_pc = ret_q.next_pc;
    assign o_redirect.stop = ret_q.halt || ret_q.trap;

    assign o_retire = ret_q;
    assign o_retire_valid = valid_q;

endmodule

/* hart_top.sv */
`timescale 1ns/100ps

module hart_top (
    input  logic                         i_clk,
    input  logic                         i_rst,
    input  logic                         i_imem_ready,
    input  logic                         i_imem_valid,
    input  logic [rv_isa_pkg::XLEN-1:0]  i_imem_rdata,
    output logic                         o_imem_ren,
    output logic [rv_isa_pkg::XLEN-1:0]  o_imem_raddr,
    output logic                         o_retire_valid,
    output hart_pkg::retire_t            o_retire
);
    import rv_isa_pkg::*;
    import hart_pkg::*;

    fetch_pkt_t            fetch;
    logic                  fetch_valid;
    decoded_t              dec;
    exec_result_t          exec;
    redirect_t             redirect;
    logic [XLEN-1:0]       rs1_data;
    logic [XLEN-1:0]       rs2_data;
    logic                  rd_wen;
    logic [REG_ADDR_W-1:0] rd_addr;
    logic [XLEN-1:0]       rd_data;

    // one instruction in flight, from the imem response through to retire
    fetch_unit u_fetch_unit (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_imem_ready  (i_imem_ready),
        .i_imem_valid  (i_imem_valid),
        .i_imem_rdata  (i_imem_rdata),
        .i_redirect    (redirect),
        .o_imem_ren    (o_imem_ren),
        .o_imem_raddr  (o_imem_raddr),
        .o_fetch_valid (fetch_valid),
        .o_fetch       (fetch)
    );

    decoder u_decoder (
        .i_fetch (fetch),
        .o_dec   (dec)
    );

    // sources are read straight from the decoded fields, used or not
    reg_file u_reg_file (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .i_rs1_addr (dec.rs1_addr),
        .i_rs2_addr (dec.rs2_addr),
        .o_rs1_data (rs1_data),
        .o_rs2_data (rs2_data),
        .i_rd_wen   (rd_wen),
        .i_rd_addr  (rd_addr),
        .i_rd_data  (rd_data)
    );

    execute_unit u_execute_unit (
        .i_dec      (dec),
        .i_pc       (fetch.pc),
        .i_rs1_data (rs1_data),
        .i_rs2_data (rs2_data),
        .o_exec     (exec)
    );

    retire_stage u_retire_stage (
        .i_clk          (i_clk),
        .i_rst          (i_rst),
        .i_fetch_valid  (fetch_valid),
        .i_fetch        (fetch),
        .i_dec          (dec),
        .i_rs1_data     (rs1_data),
        .i_rs2_data     (rs2_data),
        .i_exec         (exec),
        .o_rd_wen       (rd_wen),
        .o_rd_addr      (rd_addr),
        .o_rd_data      (rd_data),
        .o_redirect     (redirect),
        .o_retire       (o_retire),
        .o_retire_valid (o_retire_valid)
    );

endmodule

/* tb_hart.sv */
`timescale 1ns/100ps

module tb_hart;
    import rv_isa_pkg::*;
    import hart_pkg::*;

    // random body followed by a four word block that ends the run
    localparam int BODY_WORDS = 96;
    localparam int PROG_WORDS = BODY_WORDS + 4;
    localparam int MAX_WAIT = 40;
    // lw has no place in this hart, so its opcode decodes as illegal
    localparam logic [6:0] OPC_LOAD = 7'b0000011;

    logic        i_clk;
    logic        i_rst;
    logic        i_imem_ready;
    logic        i_imem_valid;
    logic [31:0] i_imem_rdata;
    logic        o_imem_ren;
    logic [31:0] o_imem_raddr;
    logic        o_retire_valid;
    retire_t     o_retire;

    logic [31:0] prog [PROG_WORDS];
    logic [31:0] model_regs [32];
    logic [31:0] model_pc;
    logic [31:0] rng_state;

    hart_top i_hart_top (
        .i_clk          (i_clk),
        .i_rst          (i_rst),
        .i_imem_ready   (i_imem_ready),
        .i_imem_valid   (i_imem_valid),
        .i_imem_rdata   (i_imem_rdata),
        .o_imem_ren     (o_imem_ren),
        .o_imem_raddr   (o_imem_raddr),
        .o_retire_valid (o_retire_valid),
        .o_retire       (o_retire)
    );

    initial i_clk = 1'b0;
    always #2 i_clk = ~i_clk;

    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // R and I formats share one layout once funct7 and rs2 are taken as the immediate
    function automatic logic [31:0] encode_i(input logic [11:0] imm, input logic [4:0] rs1,
                                             input logic [2:0] f3, input logic [4:0] rd,
                                             input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] encode_b(input logic [12:0] imm, input logic [4:0] rs2,
                                             input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    function automatic logic [31:0] encode_j(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
    endfunction

    function automatic logic [31:0] random_inst();
        logic [31:0] r;
        logic [31:0] r2;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [12:0] off;
        r = next_rand();
        r2 = next_rand();
        // only x0..x7, so sources often hit values written just before
        rd = {2'b00, r[2:0]};
        rs1 = {2'b00, r[5:3]};
        rs2 = {2'b00, r[8:6]};
        f3 = r[11:9];
        // forward jumps of one to four words
        off = {9'd0, r[13:12], 2'b00} + 13'd4;
        f7 = (r[14] && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00;
        case (r2 % 10)
            0, 1, 2: return encode_i({f7, rs2}, rs1, f3, rd, OPC_OP);
            3, 4, 5: begin
                if (f3 == 3'd1 || f3 == 3'd5) begin
                    return encode_i({f7, r2[20:16]}, rs1, f3, rd, OPC_OP_IMM);
                end
                return encode_i(r2[31:20], rs1, f3, rd, OPC_OP_IMM);
            end
            6: return {r2[31:12], rd, OPC_LUI};
            7: return {r2[31:12], rd, OPC_AUIPC};
            // reserved codes 010 and 011 are moved onto blt and bge
            8: return encode_b(off, rs2, rs1, (f3[2:1] == 2'b01) ? (f3 ^ 3'b110) : f3);
            default: return encode_j({8'd0, off}, rd);
        endcase
    endfunction

    task automatic gen_program(input logic trap_end);
        logic [31:0] last;
        if (!trap_end) begin
            last = EBREAK_WORD;
        end else if (next_rand() % 2 == 0) begin
            last = encode_i(12'h000, 5'd0, 3'b010, 5'd1, OPC_LOAD);
        end else begin
            // beq x0, x0, +6 is always taken and lands off a word boundary
            last = encode_b(13'd6, 5'd0, 5'd0, 3'b000);
        end
        for (int i = 0; i < PROG_WORDS; i++) begin
            prog[i] = (i < BODY_WORDS) ? random_inst() : last;
        end
    endtask

    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: return (a < b) ? 32'd1 : 32'd0;
            3'd4: return a ^ b;
            3'd5: begin
                if (alt) begin
                    return $signed(a) >>> b[4:0];
                end
                return a >> b[4:0];
            end
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_ref(input logic [2:0] f3, input logic [31:0] a,
                                        input logic [31:0] b);
        case (f3)
            3'd0: return a == b;
            3'd1: return a != b;
            3'd4: return $signed(a) < $signed(b);
            3'd5: return $signed(a) >= $signed(b);
            3'd6: return a < b;
            default: return a >= b;
        endcase
    endfunction

    // executes one word on the model state and returns the retire record it expects
    function automatic retire_t model_step(input logic [31:0] inst);
        retire_t     r;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic        use1;
        logic        use2;
        logic        wr;
        logic        illegal;
        rd = inst[11:7];
        rs1 = inst[19:15];
        rs2 = inst[24:20];
        f3 = inst[14:12];
        a = model_regs[rs1];
        b = model_regs[rs2];
        use1 = 1'b0;
        use2 = 1'b0;
        wr = 1'b0;
        illegal = 1'b0;
        res = '0;
        r = '0;
        r.next_pc = model_pc + 32'd4;
        case (inst[6:0])
            OPC_OP: begin
                use1 = 1'b1;
                use2 = 1'b1;
                wr = 1'b1;
                res = alu_ref(f3, inst[30], a, b);
            end
            OPC_OP_IMM: begin
                use1 = 1'b1;
                wr = 1'b1;
                // only srai reads bit 30 as an opcode bit
                res = alu_ref(f3, inst[30] && f3 == 3'd5, a, {{20{inst[31]}}, inst[31:20]});
            end
            OPC_LUI: begin
                wr = 1'b1;
                res = {inst[31:12], 12'd0};
            end
            OPC_AUIPC: begin
                wr = 1'b1;
                res = model_pc + {inst[31:12], 12'd0};
            end
            OPC_JAL: begin
                wr = 1'b1;
                res = model_pc + 32'd4;
                r.next_pc = model_pc + {{12{inst[31]}}, inst[19:12], inst[20],
                                        inst[30:21], 1'b0};
            end
            OPC_BRANCH: begin
                use1 = 1'b1;
                use2 = 1'b1;
                if (branch_ref(f3, a, b)) begin
                    r.next_pc = model_pc + {{20{inst[31]}}, inst[7], inst[30:25],
                                            inst[11:8], 1'b0};
                end
            end
            OPC_SYSTEM: begin
                r.halt = (inst == EBREAK_WORD);
                illegal = !r.halt;
            end
            default: illegal = 1'b1;
        endcase
        r.trap = illegal || (r.next_pc[1:0] != 2'b00);
        r.inst = inst;
        r.pc = model_pc;
        r.rs1_raddr = use1 ? rs1 : 5'd0;
        r.rs2_raddr = use2 ? rs2 : 5'd0;
        r.rs1_rdata = use1 ? a : 32'd0;
        r.rs2_rdata = use2 ? b : 32'd0;
        // x0 stays zero in the model because it is never written
        if (wr && !r.trap && rd != 5'd0) begin
            r.rd_waddr = rd;
            r.rd_wdata = res;
            model_regs[rd] = res;
        end
        model_pc = r.next_pc;
        return r;
    endfunction

    task automatic stop_on_failure();
        $display("Simulation failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got 0x%08h expected 0x%08h", name, got, exp);
            stop_on_failure();
        end
    endtask

    // inputs change 1 ns after the edge, outputs are read at the same point
    task automatic next_cycle();
        @(posedge i_clk);
        #1;
    endtask

    // serves one fetch with random ready and valid delays and checks its retire
    task automatic run_instruction(output logic stopped);
        int          waited;
        int          ready_delay;
        int          rsp_delay;
        logic [31:0] addr;
        logic [6:0]  idx;
        retire_t     expected;
        waited = 0;
        while (!o_imem_ren) begin
            check("o_retire_valid", 32'(o_retire_valid), 0);
            next_cycle();
            waited++;
            if (waited > MAX_WAIT) begin
                $display("timeout: the hart issued no instruction fetch request");
                stop_on_failure();
            end
        end
        addr = o_imem_raddr;
        check("o_imem_raddr", addr, model_pc);
        if (addr >= PROG_WORDS * 4) begin
            $display("fetch address 0x%08h lies outside the test program", addr);
            stop_on_failure();
        end
        idx = addr[8:2];
        ready_delay = next_rand() % 4;
        rsp_delay = next_rand() % 4;
        // the request must stay up and unchanged while ready is low
        for (int i = 0; i < ready_delay; i++) begin
            next_cycle();
            check("o_imem_ren", 32'(o_imem_ren), 1);
            check("o_imem_raddr", o_imem_raddr, addr);
            check("o_retire_valid", 32'(o_retire_valid), 0);
        end
        i_imem_ready = 1'b1;
        for (int i = 0; i < rsp_delay; i++) begin
            next_cycle();
            i_imem_ready = 1'b0;
            check("o_imem_ren", 32'(o_imem_ren), 0);
            check("o_retire_valid", 32'(o_retire_valid), 0);
        end
        i_imem_valid = 1'b1;
        i_imem_rdata = prog[idx];
        next_cycle();
        i_imem_ready = 1'b0;
        i_imem_valid = 1'b0;
        // this is the cycle right after the response
        expected = model_step(prog[idx]);
        check("o_retire_valid", 32'(o_retire_valid), 1);
        check("o_retire.inst", o_retire.inst, expected.inst);
        check("o_retire.pc", o_retire.pc, expected.pc);
        check("o_retire.next_pc", o_retire.next_pc, expected.next_pc);
        check("o_retire.trap", 32'(o_retire.trap), 32'(expected.trap));
        check("o_retire.halt", 32'(o_retire.halt), 32'(expected.halt));
        check("o_retire.rs1_raddr", 32'(o_retire.rs1_raddr), 32'(expected.rs1_raddr));
        check("o_retire.rs2_raddr", 32'(o_retire.rs2_raddr), 32'(expected.rs2_raddr));
        check("o_retire.rs1_rdata", o_retire.rs1_rdata, expected.rs1_rdata);
        check("o_retire.rs2_rdata", o_retire.rs2_rdata, expected.rs2_rdata);
        check("o_retire.rd_waddr", 32'(o_retire.rd_waddr), 32'(expected.rd_waddr));
        check("o_retire.rd_wdata", o_retire.rd_wdata, expected.rd_wdata);
        stopped = expected.halt || expected.trap;
    endtask

    // after a halt or a trap nothing may be fetched or retired again
    task automatic check_fetch_stopped();
        for (int i = 0; i <= MAX_WAIT; i++) begin
            if (o_imem_ren) begin
                $display("the hart issued a fetch request after it had stopped");
                stop_on_failure();
            end
            next_cycle();
            check("o_retire_valid", 32'(o_retire_valid), 0);
        end
    endtask

    task automatic run_program(input logic trap_end);
        logic stopped;
        int   retired;
        gen_program(trap_end);
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        model_pc = RESET_ADDR;
        i_rst = 1'b1;
        i_imem_ready = 1'b0;
        i_imem_valid = 1'b0;
        repeat (10) next_cycle();
        i_rst = 1'b0;
        check("o_imem_ren", 32'(o_imem_ren), 0);
        check("o_retire_valid", 32'(o_retire_valid), 0);
        // first request goes out one cycle after reset drops
        next_cycle();
        check("o_imem_ren", 32'(o_imem_ren), 1);
        check("o_imem_raddr", o_imem_raddr, RESET_ADDR);
        stopped = 1'b0;
        retired = 0;
        while (!stopped) begin
            run_instruction(stopped);
            retired++;
            if (!stopped && retired >= PROG_WORDS) begin
                $display("the program retired too many instructions without stopping");
                stop_on_failure();
            end
        end
        if (trap_end) begin
            check("o_retire.trap", 32'(o_retire.trap), 1);
            check("o_retire.rd_waddr", 32'(o_retire.rd_waddr), 0);
        end else begin
            check("o_retire.halt", 32'(o_retire.halt), 1);
        end
        check_fetch_stopped();
    endtask

    initial begin
        i_rst = 1'b1;
        i_imem_ready = 1'b0;
        i_imem_valid = 1'b0;
        i_imem_rdata = '0;
        rng_state = 32'd47;
        // run one ends on ebreak, run two on a trap
        run_program(1'b0);
        run_program(1'b1);
        $display("Simulation passed");
        $finish;
    end

endmodule

/* vlog.f */
rv_isa_pkg.sv
hart_pkg.sv
fetch_unit.sv
decoder.sv
reg_file.sv
execute_unit.sv
retire_stage.sv
hart_top.sv
tb_hart.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing
TOP      = tb_hart
FILELIST = vlog.f

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	grep -q "Simulation passed" sim.log

clean:
	rm -rf obj_dir sim.log
